//--- sources.f
+incdir+common
common/core_pkg.sv
rs/fu_alu.sv
rs/fu_selector.sv
rs/rs.sv
logic/map_table.sv
logic/core_top.sv
tests/core_assert.sv
tests/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := core_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/core_tb.sv
`timescale 1ns/1ns
`include "core_config.svh"

module core_tb;
    import core_pkg::*;

    typedef logic [`NUM_REGS-1:0][`DATA_W-1:0] regs_t;

    // one table row, either an instruction or a flush marker
    typedef struct packed {
        logic       is_flush;
        logic       burst;
        logic [2:0] group;
        dispatch_t  d;
    } step_t;

    localparam int SHIFT_W = $clog2(`DATA_W);
    localparam int NUM_TAGS = 1 << `TAG_W;

    logic      clock;
    logic      reset;
    logic      flush;
    logic      dispatch_req;
    dispatch_t dispatch;
    logic      dispatch_ack;
    cdb_t      cdb;
    regs_t     reg_value;

    step_t              rows[$];
    string              group_name[5];
    regs_t              shadow;
    logic [`TAG_W-1:0]  model_tag;
    logic               exp_busy[NUM_TAGS];
    logic [`REG_W-1:0]  exp_dest[NUM_TAGS];
    logic [`DATA_W-1:0] exp_value[NUM_TAGS];
    string              exp_name[NUM_TAGS];
    int                 outstanding;
    logic [15:0]        lfsr;

    core_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .dispatch_req (dispatch_req),
        .dispatch     (dispatch),
        .dispatch_ack (dispatch_ack),
        .cdb          (cdb),
        .reg_value    (reg_value)
    );

    always #4 clock = ~clock;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [3:0] random_bits(input int n);
        logic [3:0] bits;
        logic       fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            bits = {bits[2:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [`DATA_W-1:0] ref_alu(
        input alu_op_t            op,
        input logic [`DATA_W-1:0] a,
        input logic [`DATA_W-1:0] b
    );
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[SHIFT_W-1:0];
            default: return '0;
        endcase
    endfunction

    task automatic check_cdb(input string name, input cdb_t exp, input cdb_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s cdb expected tag %0d r%0d %h, actual tag %0d r%0d %h",
                name, exp.tag, exp.dest, exp.value, act.tag, act.dest, act.value));
        end
    endtask

    task automatic check_regs(input string name, input regs_t exp, input regs_t act);
        for (int r = 0; r < `NUM_REGS; r++) begin
            if (act[r] !== exp[r]) begin
                abort_run($sformatf("ERR %s r%0d expected %h actual %h",
                    name, r, exp[r], act[r]));
            end
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s dispatch_ack expected %b actual %b",
                name, exp, act));
        end
    endtask

    task automatic add_reg(input logic [2:0] grp, input alu_op_t op, input logic [2:0] dest,
                           input logic [2:0] a, input logic [2:0] b, input logic burst);
        step_t s;
        s                     = '0;
        s.group               = grp;
        s.burst               = burst;
        s.d.op                = op;
        s.d.dest              = dest;
        s.d.src_a             = a;
        s.d.operand_b.src.idx = b;
        rows.push_back(s);
    endtask

    task automatic add_imm(input logic [2:0] grp, input alu_op_t op, input logic [2:0] dest,
                           input logic [2:0] a, input logic [`DATA_W-1:0] imm);
        step_t s;
        s                 = '0;
        s.group           = grp;
        s.d.op            = op;
        s.d.dest          = dest;
        s.d.src_a         = a;
        s.d.use_imm       = 1'b1;
        s.d.operand_b.imm = imm;
        rows.push_back(s);
    endtask

    task automatic add_flush();
        step_t s;
        s          = '0;
        s.is_flush = 1'b1;
        rows.push_back(s);
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    task automatic build_table();
        group_name = '{"independent", "chain", "fill", "two_writes", "after_flush"};
        add_imm(0, ALU_ADD, 1, 0, 16'h0012);
        add_imm(0, ALU_ADD, 2, 0, 16'h0345);
        add_reg(0, ALU_ADD, 3, 1, 2, 1'b0);
        add_imm(0, ALU_XOR, 4, 2, 16'h0ff0);
        add_imm(0, ALU_SLL, 5, 1, 16'h0004);
        add_reg(0, ALU_SUB, 6, 2, 1, 1'b0);
        add_imm(0, ALU_AND, 7, 3, 16'h00f0);
        add_imm(0, ALU_OR,  0, 1, 16'h1234);
        add_imm(1, ALU_ADD, 1, 1, 16'h0001);
        add_reg(1, ALU_ADD, 2, 1, 1, 1'b0);
        add_reg(1, ALU_SUB, 3, 2, 1, 1'b0);
        add_reg(1, ALU_OR,  1, 3, 2, 1'b0);
        add_imm(1, ALU_SLL, 4, 1, 16'h0003);
        add_reg(1, ALU_XOR, 5, 4, 3, 1'b0);
        // back to back, no idle gap between handshakes
        add_reg(2, ALU_ADD, 2, 1, 2, 1'b1);
        add_reg(2, ALU_ADD, 3, 2, 1, 1'b1);
        add_reg(2, ALU_XOR, 4, 3, 2, 1'b1);
        add_reg(2, ALU_ADD, 5, 4, 3, 1'b1);
        add_reg(2, ALU_AND, 6, 5, 4, 1'b1);
        add_reg(2, ALU_OR,  7, 6, 5, 1'b1);
        add_reg(3, ALU_SLL, 5, 7, 1, 1'b1);
        add_imm(3, ALU_ADD, 5, 0, 16'h0077);
        add_imm(3, ALU_ADD, 6, 5, 16'h0001);
        add_flush();
        add_imm(4, ALU_ADD, 1, 0, 16'h0a0a);
        add_imm(4, ALU_SUB, 2, 1, 16'h0003);
        add_reg(4, ALU_XOR, 3, 2, 1, 1'b0);
        add_imm(4, ALU_SLL, 7, 3, 16'h0002);
    endtask

    task automatic clear_model();
        shadow    = '0;
        model_tag = 1;
        for (int t = 0; t < NUM_TAGS; t++) begin
            exp_busy[t] = 1'b0;
        end
    endtask

    // four-phase handshake, entered 1 ns after an edge
    // expected result recorded in the ack cycle
    task automatic dispatch_one(input step_t row);
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`TAG_W-1:0]  tag;
        dispatch     = row.d;
        dispatch_req = 1'b1;
        do begin
            @(posedge clock);
            #1;
        end while (!dispatch_ack);
        a   = shadow[row.d.src_a];
        b   = row.d.use_imm ? row.d.operand_b.imm : shadow[row.d.operand_b.src.idx];
        tag = model_tag;
        if (exp_busy[tag]) begin
            abort_run($sformatf("tag %0d was handed out again while still in flight", tag));
        end
        exp_busy[tag]  = 1'b1;
        exp_dest[tag]  = row.d.dest;
        exp_value[tag] = ref_alu(row.d.op, a, b);
        exp_name[tag]  = group_name[row.group];
        outstanding++;
        if (row.d.dest != '0) begin
            shadow[row.d.dest] = exp_value[tag];
        end
        model_tag    = (model_tag == '1) ? 1 : model_tag + 1'b1;
        dispatch_req = 1'b0;
        do begin
            @(posedge clock);
            #1;
        end while (dispatch_ack);
    endtask

    task automatic wait_idle();
        while (outstanding != 0) begin
            @(posedge clock);
            #1;
        end
        repeat (2) @(posedge clock);
        #1;
    endtask

    //////////////////////////////////////////////////
    // checking and main sequence
    //////////////////////////////////////////////////

    // every broadcast must match the instruction that owns its tag
    always @(negedge clock) begin
        cdb_t exp;
        if (!reset && cdb.valid) begin
            if (!exp_busy[cdb.tag]) begin
                abort_run($sformatf("broadcast on tag %0d with nothing in flight", cdb.tag));
            end
            exp       = '0;
            exp.valid = 1'b1;
            exp.tag   = cdb.tag;
            exp.dest  = exp_dest[cdb.tag];
            exp.value = exp_value[cdb.tag];
            check_cdb(exp_name[cdb.tag], exp, cdb);
            exp_busy[cdb.tag] = 1'b0;
            outstanding--;
        end
    end

    initial begin
        #1;
        repeat (rows.size() * 200) @(posedge clock);
        abort_run("timeout, the run did not reach its end");
    end

    initial begin
        logic [3:0] gap;
        clock        = 1'b0;
        reset        = 1'b1;
        flush        = 1'b0;
        dispatch_req = 1'b0;
        dispatch     = '0;
        lfsr         = 16'd33741;
        outstanding  = 0;
        build_table();
        clear_model();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        check_regs("reset", shadow, reg_value);
        check_ack("reset", 1'b0, dispatch_ack);
        check_cdb("reset", '0, cdb);
        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].is_flush) begin
                wait_idle();
                check_regs("before_flush", shadow, reg_value);
                flush = 1'b1;
                @(posedge clock);
                #1;
                flush = 1'b0;
                clear_model();
                check_regs("flush", shadow, reg_value);
                check_ack("flush", 1'b0, dispatch_ack);
                check_cdb("flush", '0, cdb);
            end else begin
                dispatch_one(rows[i]);
                if (!rows[i].burst) begin
                    gap = random_bits(2);
                    repeat (gap) begin
                        @(posedge clock);
                        #1;
                    end
                end
            end
        end
        wait_idle();
        check_regs("final", shadow, reg_value);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- tests/core_assert.sv
`timescale 1ns/1ns
`include "core_config.svh"

module core_assert (
    input logic                clock,
    input logic                reset,
    input logic                flush,
    input logic                dispatch_req,
    input logic                dispatch_ack,
    input logic [`RS_SIZE-1:0] grant
);

    //////////////////////////////////////////////////
    // dispatch handshake
    //////////////////////////////////////////////////

    ack_needs_req: assert property (@(posedge clock) disable iff (reset || flush)
        $rose(dispatch_ack) |-> $past(dispatch_req))
        else $error("dispatch_ack rose without a request");

    // next request only after the previous ack is gone
    req_after_ack: assert property (@(posedge clock) disable iff (reset || flush)
        $rose(dispatch_req) |-> !dispatch_ack)
        else $error("dispatch_req rose while dispatch_ack was still high");

    // one broadcast per cycle at most
    grant_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(grant))
        else $error("more than one functional unit granted the CDB");

endmodule

bind core_top core_assert u_core_assert (
    .clock        (clock),
    .reset        (reset),
    .flush        (flush),
    .dispatch_req (dispatch_req),
    .dispatch_ack (dispatch_ack),
    .grant        (u_rs.grant)
);

//--- logic/core_top.sv
`timescale 1ns/1ns
`include "core_config.svh"

module core_top (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               flush,
    input  logic                               dispatch_req,
    input  core_pkg::dispatch_t                dispatch,
    output logic                               dispatch_ack,
    output core_pkg::cdb_t                     cdb,
    output logic [`NUM_REGS-1:0][`DATA_W-1:0]  reg_value
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        HS_IDLE,
        HS_ALLOC,
        HS_HOLD
    } hs_state_t;

    hs_state_t state;
    hs_state_t next_state;
    logic      alloc;
    logic      full;
    mt_rs_t    mt_rs;

    //////////////////////////////////////////////////
    // four-phase dispatch handshake
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            // wait for a free slot before acking
            HS_IDLE:  if (dispatch_req && !full) next_state = HS_ALLOC;
            HS_ALLOC: next_state = dispatch_req ? HS_HOLD : HS_IDLE;
            HS_HOLD:  if (!dispatch_req) next_state = HS_IDLE;
            default:  next_state = HS_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            state <= HS_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // alloc strobe in the first ack cycle only
    assign alloc        = (state == HS_ALLOC);
    assign dispatch_ack = (state != HS_IDLE);

    map_table u_map_table (
        .clock     (clock),
        .reset     (reset),
        .flush     (flush),
        .alloc     (alloc),
        .disp      (dispatch),
        .cdb       (cdb),
        .mt_rs     (mt_rs),
        .reg_value (reg_value)
    );

    rs u_rs (
        .clock (clock),
        .reset (reset),
        .flush (flush),
        .alloc (alloc),
        .disp  (dispatch),
        .mt_rs (mt_rs),
        .cdb   (cdb),
        .full  (full)
    );

endmodule

//--- logic/map_table.sv
`timescale 1ns/1ns
`include "core_config.svh"

module map_table (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               flush,
    input  logic                               alloc,
    input  core_pkg::dispatch_t                disp,
    input  core_pkg::cdb_t                     cdb,
    output core_pkg::mt_rs_t                   mt_rs,
    output logic [`NUM_REGS-1:0][`DATA_W-1:0]  reg_value
);
    import core_pkg::*;

    localparam logic [`TAG_W-1:0] FIRST_TAG = 1;

    // producer tag per register, 0 when the value is in reg_value
    logic [`NUM_REGS-1:0][`TAG_W-1:0] tags;
    logic [`TAG_W-1:0]                next_tag;
    logic [`REG_W-1:0]                src_b_reg;

    function automatic src_info_t lookup(
        logic [`TAG_W-1:0]  tag,
        logic [`DATA_W-1:0] value,
        cdb_t               c
    );
        src_info_t s;
        s.tag   = tag;
        s.value = value;
        s.ready = 1'b1;
        if (tag != '0) begin
            // producer broadcasting right now
            if (c.valid && c.tag == tag) begin
                s.value = c.value;
            end else begin
                s.value = '0;
                s.ready = 1'b0;
            end
        end
        return s;
    endfunction

    // only meaningful when use_imm is clear, rs picks the immediate otherwise
    assign src_b_reg = disp.operand_b.src.idx;

    always_comb begin
        mt_rs.src_a    = lookup(tags[disp.src_a], reg_value[disp.src_a], cdb);
        mt_rs.src_b    = lookup(tags[src_b_reg], reg_value[src_b_reg], cdb);
        mt_rs.dest_tag = next_tag;
    end

    //////////////////////////////////////////////////
    // writeback and rename
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            reg_value <= '0;
            tags      <= '0;
            next_tag  <= FIRST_TAG;
        end else begin
            // stale producers never overwrite a younger one
            if (cdb.valid && cdb.dest != '0 && tags[cdb.dest] == cdb.tag) begin
                reg_value[cdb.dest] <= cdb.value;
                tags[cdb.dest]      <= '0;
            end
            // a new rename of the same register takes precedence
            if (alloc) begin
                if (disp.dest != '0) begin
                    tags[disp.dest] <= next_tag;
                end
                next_tag <= (next_tag == '1) ? FIRST_TAG : next_tag + 1'b1;
            end
        end
    end

endmodule

//--- rs/rs.sv
`timescale 1ns/1ns
`include "core_config.svh"

module rs (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                alloc,
    input  core_pkg::dispatch_t disp,
    input  core_pkg::mt_rs_t    mt_rs,
    output core_pkg::cdb_t      cdb,
    output logic                full
);
    import core_pkg::*;

    rs_entry_t [`RS_SIZE-1:0]         entries;
    rs_entry_t [`RS_SIZE-1:0]         next_entries;
    logic [`RS_SIZE-1:0]              busy;
    logic [`RS_SIZE-1:0]              start;
    logic [`RS_SIZE-1:0]              done;
    logic [`RS_SIZE-1:0]              grant;
    logic [`RS_SIZE-1:0][`DATA_W-1:0] result;
    src_info_t                        imm_b;

    // capture a broadcast value for an operand still waiting on it
    function automatic src_info_t snoop(src_info_t s, cdb_t c);
        src_info_t r;
        r = s;
        if (c.valid && !s.ready && s.tag == c.tag) begin
            r.value = c.value;
            r.ready = 1'b1;
        end
        return r;
    endfunction

    // immediate operand is ready at dispatch
    assign imm_b = '{tag: '0, value: disp.operand_b.imm, ready: 1'b1};

    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            busy[i]  = entries[i].busy;
            start[i] = entries[i].busy && entries[i].src_a.ready &&
                       entries[i].src_b.ready && !done[i];
        end
    end

    assign full = &busy;

    //////////////////////////////////////////////////
    // functional units and result arbitration
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `RS_SIZE; i++) begin : g_fu
        fu_alu u_fu_alu (
            .clock  (clock),
            .reset  (reset),
            .flush  (flush),
            .start  (start[i]),
            .op     (entries[i].op),
            .a      (entries[i].src_a.value),
            .b      (entries[i].src_b.value),
            .grant  (grant[i]),
            .done   (done[i]),
            .result (result[i])
        );
    end

    fu_selector u_fu_selector (
        .clock (clock),
        .reset (reset),
        .done  (done),
        .grant (grant)
    );

    // cdb driven straight from the granted unit
    always_comb begin
        cdb = '0;
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (grant[i]) begin
                cdb.valid = 1'b1;
                cdb.tag   = entries[i].dest_tag;
                cdb.dest  = entries[i].dest;
                cdb.value = result[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // entry update
    //////////////////////////////////////////////////

    always_comb begin
        logic placed;
        next_entries = entries;
        placed       = 1'b0;

        // granted entry leaves at the next edge
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (grant[i]) begin
                next_entries[i].busy = 1'b0;
            end
        end

        // new instruction into the lowest free slot
        if (alloc) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (!entries[i].busy && !placed) begin
                    placed                   = 1'b1;
                    next_entries[i].busy     = 1'b1;
                    next_entries[i].dest_tag = mt_rs.dest_tag;
                    next_entries[i].dest     = disp.dest;
                    next_entries[i].op       = disp.op;
                    next_entries[i].src_a    = mt_rs.src_a;
                    next_entries[i].src_b    = disp.use_imm ? imm_b : mt_rs.src_b;
                end
            end
        end

        // wake up waiting operands
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (next_entries[i].busy) begin
                next_entries[i].src_a = snoop(next_entries[i].src_a, cdb);
                next_entries[i].src_b = snoop(next_entries[i].src_b, cdb);
            end
        end
    end

    always_ff @(posedge clock) begin
        entries <= next_entries;
        if (reset || flush) begin
            for (int i = 0; i < `RS_SIZE; i++) begin
                entries[i].busy <= 1'b0;
            end
        end
    end

endmodule

//--- rs/fu_selector.sv
`timescale 1ns/1ns
`include "core_config.svh"

module fu_selector (
    input  logic                clock,
    input  logic                reset,
    input  logic [`RS_SIZE-1:0] done,
    output logic [`RS_SIZE-1:0] grant
);

    localparam int PTR_W = (`RS_SIZE > 1) ? $clog2(`RS_SIZE) : 1;

    // highest priority unit this cycle
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] winner;
    logic             any;

    always_comb begin
        int idx;
        grant  = '0;
        winner = ptr;
        any    = 1'b0;
        // scan starting at the pointer, first done unit wins
        for (int k = 0; k < `RS_SIZE; k++) begin
            idx = (int'(ptr) + k) % `RS_SIZE;
            if (!any && done[idx]) begin
                grant[idx] = 1'b1;
                winner     = PTR_W'(idx);
                any        = 1'b1;
            end
        end
    end

    // pointer moves one past the last winner
    always_ff @(posedge clock) begin
        if (reset) begin
            ptr <= '0;
        end else if (any) begin
            if (int'(winner) == `RS_SIZE - 1) begin
                ptr <= '0;
            end else begin
                ptr <= winner + 1'b1;
            end
        end
    end

endmodule

//--- rs/fu_alu.sv
`timescale 1ns/1ns
`include "core_config.svh"

module fu_alu (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                start,
    input  core_pkg::alu_op_t   op,
    input  logic [`DATA_W-1:0]  a,
    input  logic [`DATA_W-1:0]  b,
    input  logic                grant,
    output logic                done,
    output logic [`DATA_W-1:0]  result
);
    import core_pkg::*;

    localparam int SHAMT_W = $clog2(`DATA_W);

    logic [`DATA_W-1:0] alu_out;

    always_comb begin
        case (op)
            ALU_ADD: alu_out = a + b;
            ALU_SUB: alu_out = a - b;
            ALU_AND: alu_out = a & b;
            ALU_OR:  alu_out = a | b;
            ALU_XOR: alu_out = a ^ b;
            // only the low bits of b count as shift amount
            ALU_SLL: alu_out = a << b[SHAMT_W-1:0];
            default: alu_out = '0;
        endcase
    end

    // done holds until the arbiter takes the result
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            done <= 1'b0;
        end else if (done) begin
            if (grant) begin
                done <= 1'b0;
            end
        end else if (start) begin
            done <= 1'b1;
        end
    end

    // result register, loaded on an accepted start
    always_ff @(posedge clock) begin
        if (start && !done) begin
            result <= alu_out;
        end
    end

endmodule

//--- common/core_pkg.sv
`include "core_config.svh"

package core_pkg;

    //////////////////////////////////////////////////
    // instruction fields
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5
    } alu_op_t;

    // operand b, register index or immediate depending on use_imm
    typedef union packed {
        struct packed {
            logic [`DATA_W-`REG_W-1:0] pad;
            logic [`REG_W-1:0]         idx;
        } src;
        logic [`DATA_W-1:0] imm;
    } operand_b_t;

    typedef struct packed {
        alu_op_t            op;
        logic [`REG_W-1:0]  dest;
        logic [`REG_W-1:0]  src_a;
        logic               use_imm;
        operand_b_t         operand_b;
    } dispatch_t;

    //////////////////////////////////////////////////
    // rename and broadcast
    //////////////////////////////////////////////////

    // one source operand, ready means value is valid
    typedef struct packed {
        logic [`TAG_W-1:0]  tag;
        logic [`DATA_W-1:0] value;
        logic               ready;
    } src_info_t;

    typedef struct packed {
        src_info_t          src_a;
        src_info_t          src_b;
        logic [`TAG_W-1:0]  dest_tag;
    } mt_rs_t;

    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        logic [`REG_W-1:0]  dest;
        logic [`DATA_W-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic               busy;
        logic [`TAG_W-1:0]  dest_tag;
        logic [`REG_W-1:0]  dest;
        alu_op_t            op;
        src_info_t          src_a;
        src_info_t          src_b;
    } rs_entry_t;

endpackage

//--- common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

//////////////////////////////////////////////////
// core sizing
//////////////////////////////////////////////////

// reservation station entries, one alu behind each
`define RS_SIZE 4

// architectural registers, r0 hardwired to zero
`define NUM_REGS 8

// register index width
`define REG_W 3

// operand and result width
`define DATA_W 16

// rename tag width, tag 0 = value already in the register file
`define TAG_W 4

`endif
